// ==== rtl/aes_math_pkg.sv ====
`default_nettype none

package aes_math_pkg;

  ////////////////////////////////////////
  // gf(2^8) constants
  ////////////////////////////////////////

  // low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
  localparam logic [7:0] poly_reduce = 8'h1b;

  ////////////////////////////////////////
  // forward s-box
  ////////////////////////////////////////

  // row picked by the high nibble, entry by the low nibble
  localparam logic [0:15][0:15][7:0] sbox = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  ////////////////////////////////////////
  // byte helpers
  ////////////////////////////////////////

  // one byte through the s-box
  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [3:0] row;
    logic [3:0] col;
    row = b[7:4];
    col = b[3:0];
    return sbox[row][col];
  endfunction

  // multiply by 02
  function automatic logic [7:0] xtime(input logic [7:0] b);
    logic [7:0] shifted;
    shifted = {b[6:0], 1'b0};
    // reduce only on carry out of bit 7
    if (b[7]) begin
      shifted = shifted ^ poly_reduce;
    end
    return shifted;
  endfunction

  // multiply by 03, i.e. 02 plus 01
  function automatic logic [7:0] mul3(input logic [7:0] b);
    return xtime(b) ^ b;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/aes_round_pkg.sv ====
`default_nettype none

package aes_round_pkg;

  // state geometry, fixed by the standard
  localparam int NUM_COLS = 4;
  localparam int COL_BYTES = 4;

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////

  typedef logic [7:0] aes_byte_t;

  // byte 0 is row 0 and the most significant
  typedef aes_byte_t [0:COL_BYTES-1] aes_col_t;

  // column 0 sits in the top 32 bits
  typedef aes_col_t [0:NUM_COLS-1] aes_state_t;

  ////////////////////////////////////////
  // pipeline packets
  ////////////////////////////////////////

  // round request from the outside
  typedef struct packed {
    aes_state_t state;
    aes_state_t key;
    logic       keyless;
  } round_in_t;

  // after sub/shift, key rides along with its data
  typedef struct packed {
    aes_state_t state;
    aes_state_t key;
    logic       keyless;
  } stage1_t;

endpackage

`default_nettype wire

// ==== rtl/aes_mix_column.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_mix_column (
  input  wire aes_round_pkg::aes_col_t col_in,
  output aes_round_pkg::aes_col_t      col_out
);

  aes_round_pkg::aes_byte_t a0;
  aes_round_pkg::aes_byte_t a1;
  aes_round_pkg::aes_byte_t a2;
  aes_round_pkg::aes_byte_t a3;

  assign a0 = col_in[0];
  assign a1 = col_in[1];
  assign a2 = col_in[2];
  assign a3 = col_in[3];

  // circulant matrix rows
  //   02 03 01 01
  //   01 02 03 01
  //   01 01 02 03
  //   03 01 01 02
  assign col_out[0] = aes_math_pkg::xtime(a0) ^ aes_math_pkg::mul3(a1) ^ a2 ^ a3;
  assign col_out[1] = a0 ^ aes_math_pkg::xtime(a1) ^ aes_math_pkg::mul3(a2) ^ a3;
  assign col_out[2] = a0 ^ a1 ^ aes_math_pkg::xtime(a2) ^ aes_math_pkg::mul3(a3);
  assign col_out[3] = aes_math_pkg::mul3(a0) ^ a1 ^ a2 ^ aes_math_pkg::xtime(a3);

endmodule

`default_nettype wire

// ==== rtl/aes_sub_shift_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_sub_shift_stage (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    in_valid,
  input  wire aes_round_pkg::round_in_t in_data,
  output logic                         s1_valid,
  output aes_round_pkg::stage1_t       s1_data
);

  aes_round_pkg::aes_state_t subbed;
  aes_round_pkg::aes_state_t shifted;

  ////////////////////////////////////////
  // subbytes
  ////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < aes_round_pkg::NUM_COLS; c++) begin
      for (int r = 0; r < aes_round_pkg::COL_BYTES; r++) begin
        subbed[c][r] = aes_math_pkg::sub_byte(in_data.state[c][r]);
      end
    end
  end

  ////////////////////////////////////////
  // shiftrows
  ////////////////////////////////////////

  // row r rotates left by r, so output column c takes row r from column c+r
  always_comb begin
    for (int c = 0; c < aes_round_pkg::NUM_COLS; c++) begin
      for (int r = 0; r < aes_round_pkg::COL_BYTES; r++) begin
        shifted[c][r] = subbed[(c + r) % aes_round_pkg::NUM_COLS][r];
      end
    end
  end

  // valid tracks the input one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // payload only loads when a round arrives
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_data.state   <= shifted;
      s1_data.key     <= in_data.key;
      s1_data.keyless <= in_data.keyless;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/aes_mix_key_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_mix_key_stage (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  s1_valid,
  input  wire aes_round_pkg::stage1_t s1_data,
  output logic                       out_valid,
  output aes_round_pkg::aes_state_t  out_state
);

  aes_round_pkg::aes_state_t mixed;
  aes_round_pkg::aes_state_t keyed;

  ////////////////////////////////////////
  // mixcolumns, one unit per column
  ////////////////////////////////////////

  for (genvar c = 0; c < aes_round_pkg::NUM_COLS; c++) begin : g_col
    aes_mix_column u_mix (
      .col_in  (s1_data.state[c]),
      .col_out (mixed[c])
    );
  end

  ////////////////////////////////////////
  // addroundkey
  ////////////////////////////////////////

  // keyless rounds skip the key add
  assign keyed = s1_data.keyless ? mixed : (mixed ^ s1_data.key);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  // result register, held between rounds
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_state <= keyed;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/aes_round_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_round_top (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    in_valid,
  input  wire aes_round_pkg::round_in_t in_data,
  output logic                         out_valid,
  output aes_round_pkg::aes_state_t    out_state
);

  // between the two stages
  logic                   s1_valid;
  aes_round_pkg::stage1_t s1_data;

  ////////////////////////////////////////
  // stage 1: subbytes and shiftrows
  ////////////////////////////////////////

  aes_sub_shift_stage u_sub_shift (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_data  (in_data),
    .s1_valid (s1_valid),
    .s1_data  (s1_data)
  );

  ////////////////////////////////////////
  // stage 2: mixcolumns and round key
  ////////////////////////////////////////

  aes_mix_key_stage u_mix_key (
    .clk       (clk),
    .rst       (rst),
    .s1_valid  (s1_valid),
    .s1_data   (s1_data),
    .out_valid (out_valid),
    .out_state (out_state)
  );

endmodule

`default_nettype wire

// ==== tb/aes_round_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_round_checker (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      in_valid,
  input  wire aes_round_pkg::round_in_t  in_data,
  input  wire logic                      out_valid,
  input  wire aes_round_pkg::aes_state_t out_state,
  input  wire logic [1:0]                exp_mode,
  input  wire aes_round_pkg::aes_state_t exp_state,
  input  wire logic [7:0]                exp_ref,
  output int                             issued,
  output int                             retired,
  output int                             value_errors,
  output int                             timing_errors
);

  localparam int DEPTH = 64;
  localparam int LATENCY = 2;
  localparam logic [1:0] MODE_EXACT = 2'd1;
  localparam logic [1:0] MODE_REL = 2'd2;

  // one slot per accepted round in input order
  logic [1:0]                mode_a  [DEPTH];
  aes_round_pkg::aes_state_t want_a  [DEPTH];
  aes_round_pkg::aes_state_t key_a   [DEPTH];
  logic [7:0]                ref_a   [DEPTH];
  int                        stamp_a [DEPTH];
  aes_round_pkg::aes_state_t seen_a  [DEPTH];

  int   cycle;
  logic armed;

  task automatic compare_state(input int idx, input aes_round_pkg::aes_state_t want);
    if (out_state !== want) begin
      $display("ERROR t=%0t out_state round %0d exp=%h got=%h", $time, idx, want, out_state);
      value_errors++;
    end
  endtask

  ////////////////////////////////////////
  // input side sampled on the rising edge
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      cycle = 0;
      issued = 0;
      armed = 1'b0;
    end else begin
      armed = 1'b1;
      cycle = cycle + 1;
      if (in_valid === 1'b1) begin
        if (issued < DEPTH) begin
          // in_valid was high during the cycle this edge closes
          stamp_a[issued] = cycle - 1;
          mode_a[issued] = exp_mode;
          want_a[issued] = exp_state;
          key_a[issued] = in_data.key;
          ref_a[issued] = exp_ref;
          issued++;
        end else begin
          $display("checker slots exhausted at time %0t", $time);
          timing_errors++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // output side sampled mid cycle
  ////////////////////////////////////////

  always @(negedge clk) begin : watch_out
    aes_round_pkg::aes_state_t want;
    int lat;
    if (armed !== 1'b1) begin
      retired = 0;
      value_errors = 0;
      timing_errors = 0;
    end else begin
      // slot for the oldest round went by without a pulse
      if (retired < issued && cycle - stamp_a[retired] > LATENCY) begin
        $display("round %0d gave no result %0d cycles after its input, time %0t",
                 retired, LATENCY, $time);
        timing_errors++;
        seen_a[retired] = '0;
        retired++;
      end
      if (out_valid === 1'b1) begin
        if (retired >= issued) begin
          $display("out_valid pulse with no round in flight at time %0t", $time);
          timing_errors++;
        end else begin
          lat = cycle - stamp_a[retired];
          if (lat != LATENCY) begin
            $display("ERROR t=%0t out_valid latency round %0d exp=%0d got=%0d",
                     $time, retired, LATENCY, lat);
            timing_errors++;
          end
          seen_a[retired] = out_state;
          if (mode_a[retired] == MODE_EXACT) begin
            compare_state(retired, want_a[retired]);
          end else if (mode_a[retired] == MODE_REL) begin
            if (int'(ref_a[retired]) >= retired) begin
              $display("round %0d refers to round %0d, which has no result yet",
                       retired, ref_a[retired]);
              value_errors++;
            end else begin
              // key add is the last step, so keyed = keyless of same state ^ key
              want = seen_a[ref_a[retired]] ^ key_a[retired];
              compare_state(retired, want);
            end
          end
          retired++;
        end
      end else if (out_valid !== 1'b0) begin
        $display("out_valid is unknown at time %0t", $time);
        timing_errors++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_aes_round.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_aes_round;

  localparam int NUM_PAIRS = 6;
  localparam int NUM_ROWS = 3 + 2 * NUM_PAIRS;
  localparam int DRAIN_LIMIT = 20;

  // result modes, same codes as the checker
  localparam logic [1:0] MODE_FREE = 2'd0;
  localparam logic [1:0] MODE_EXACT = 2'd1;
  localparam logic [1:0] MODE_REL = 2'd2;

  typedef struct packed {
    aes_round_pkg::aes_state_t state;
    aes_round_pkg::aes_state_t key;
    logic                      keyless;
    logic [1:0]                mode;
    aes_round_pkg::aes_state_t want;
    logic [7:0]                ref_idx;
    logic [1:0]                gap;
  } row_t;

  logic                      clk;
  logic                      rst;
  logic                      in_valid;
  aes_round_pkg::round_in_t  in_data;
  logic                      out_valid;
  aes_round_pkg::aes_state_t out_state;

  logic [1:0]                exp_mode;
  aes_round_pkg::aes_state_t exp_state;
  logic [7:0]                exp_ref;

  int          issued;
  int          retired;
  int          value_errors;
  int          timing_errors;
  int          other_errors;
  logic [31:0] rng_state;
  row_t        rows [NUM_ROWS];

  aes_round_top DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_state (out_state)
  );

  aes_round_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .out_valid     (out_valid),
    .out_state     (out_state),
    .exp_mode      (exp_mode),
    .exp_state     (exp_state),
    .exp_ref       (exp_ref),
    .issued        (issued),
    .retired       (retired),
    .value_errors  (value_errors),
    .timing_errors (timing_errors)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // random data
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic aes_round_pkg::aes_state_t rand_state();
    logic [127:0] v;
    v = '0;
    for (int w = 0; w < 4; w++) begin
      v = {v[95:0], next_rand()};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic fill_rows();
    aes_round_pkg::aes_state_t s;
    aes_round_pkg::aes_state_t k;
    int base;
    // fips-197 round 1, keyed and bare
    rows[0] = '{state: 128'h193de3bea0f4e22b9ac68d2ae9f84808,
                key: 128'ha0fafe1788542cb123a339392a6c7605, keyless: 1'b0,
                mode: MODE_EXACT, want: 128'ha49c7ff2689f352b6b5bea43026a5049,
                ref_idx: 8'd0, gap: 2'd0};
    rows[1] = '{state: 128'h193de3bea0f4e22b9ac68d2ae9f84808,
                key: 128'ha0fafe1788542cb123a339392a6c7605, keyless: 1'b1,
                mode: MODE_EXACT, want: 128'h046681e5e0cb199a48f8d37a2806264c,
                ref_idx: 8'd0, gap: 2'd1};
    // s-box of zero is 63, and a uniform state passes through shift and mix
    rows[2] = '{state: '0, key: rand_state(), keyless: 1'b1, mode: MODE_EXACT,
                want: {16{8'h63}}, ref_idx: 8'd0, gap: 2'd2};
    for (int p = 0; p < NUM_PAIRS; p++) begin
      base = 3 + 2 * p;
      s = rand_state();
      k = rand_state();
      rows[base] = '{state: s, key: k, keyless: 1'b1, mode: MODE_FREE,
                     want: '0, ref_idx: 8'd0, gap: 2'd0};
      rows[base + 1] = '{state: s, key: k, keyless: 1'b0, mode: MODE_REL,
                         want: '0, ref_idx: 8'(base), gap: 2'(p % 3)};
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic drive_row(input int i);
    in_valid = 1'b1;
    in_data.state = rows[i].state;
    in_data.key = rows[i].key;
    in_data.keyless = rows[i].keyless;
    exp_mode = rows[i].mode;
    exp_state = rows[i].want;
    exp_ref = rows[i].ref_idx;
    @(negedge clk);
    in_valid = 1'b0;
    repeat (rows[i].gap) @(negedge clk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (retired < issued && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (retired < issued) begin
      $display("timeout: %0d rounds still in flight after %0d cycles",
               issued - retired, DRAIN_LIMIT);
      other_errors++;
    end
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    exp_mode = MODE_FREE;
    exp_state = '0;
    exp_ref = '0;
    other_errors = 0;
    rng_state = 32'd81283;
    fill_rows();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // idle while the checker watches out_valid stay low
    repeat (3) @(negedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      drive_row(i);
    end
    wait_drain();
    repeat (4) @(posedge clk);
    if (issued != NUM_ROWS) begin
      $display("checker saw %0d rounds but %0d were driven", issued, NUM_ROWS);
      other_errors++;
    end
    $display("errors: value %0d, timing %0d, other %0d",
             value_errors, timing_errors, other_errors);
    if (value_errors + timing_errors + other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/aes_math_pkg.sv
rtl/aes_round_pkg.sv
rtl/aes_mix_column.sv
rtl/aes_sub_shift_stage.sv
rtl/aes_mix_key_stage.sv
rtl/aes_round_top.sv
tb/aes_round_checker.sv
tb/tb_aes_round.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_aes_round
out=$(./obj_dir/Vtb_aes_round)
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
else
  exit 1
fi
